// ==== design/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    // ------------------------------
    // sizing
    // ------------------------------
    localparam int NUM_LANES   = 4;             // decode lanes in the round-robin set
    localparam int LANE_DEPTH  = 2;             // entries per lane and credits per lane
    localparam int IN_DEPTH    = 2;             // dispatcher input buffer entries
    localparam int OUT_CREDITS = 4;             // downstream credits after reset

    localparam int LANE_IDX_W = $clog2(NUM_LANES);
    localparam int LANE_PTR_W = $clog2(LANE_DEPTH);
    localparam int LANE_CNT_W = $clog2(LANE_DEPTH + 1);
    localparam int IN_PTR_W   = $clog2(IN_DEPTH);
    localparam int IN_CNT_W   = $clog2(IN_DEPTH + 1);
    localparam int OUT_CNT_W  = $clog2(OUT_CREDITS + 1);

    // ------------------------------
    // encodings
    // ------------------------------
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,                      // not decoded by the control ROM
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_ops;

    // ------------------------------
    // structs
    // ------------------------------
    typedef struct packed {
        lc3b_opcode opcode;
        logic       load_pc;
        logic       load_ir;
        logic       load_regfile;
        logic       load_mar;
        logic       load_mdr;
        logic       load_cc;
        logic       regfile_filter_enable;      // zero extend the low byte on LDB
        logic       stb_filter_enable;          // replicate the low byte on STB
        logic [1:0] pcmux_sel;
        logic       brmux_sel;
        logic       storemux_sel;
        logic       destmux_sel;                // selects R7 as destination
        logic [1:0] alumux_sel;
        logic [1:0] regfilemux_sel;
        logic [1:0] marmux_sel;
        logic       mdrmux_sel;
        logic       offsetaddermux_sel;
        logic       offset6mux_sel;
        alu_ops     aluop;
        logic       mem_read;
        logic       mem_write;
        logic       indirect_enable;
        logic [1:0] mem_byte_enable;
    } lc3b_control_word;

    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] ir;
        logic        addr_lsb;                  // low bit of the effective address
    } decode_in_t;

    typedef struct packed {
        logic [15:0]      pc;
        logic [15:0]      ir;
        lc3b_control_word ctrl;
        logic [2:0]       dest;
        logic [2:0]       sr1;
        logic [2:0]       sr2;
    } decode_out_t;

endpackage

`default_nettype wire

// ==== design/control_rom.sv ====
`default_nettype none

module control_rom import lc3b_types::*; (
    input  lc3b_opcode       opcode,
    input  logic             imm_enable,
    input  logic             jsr_enable,
    input  logic             d_enable,
    input  logic             stb_high_enable,
    input  logic             is_nop,
    output lc3b_control_word ctrl
);

    always_comb begin
        // every field starts cleared except the opcode and the full word byte enable
        ctrl                 = '0;
        ctrl.opcode          = opcode;
        ctrl.aluop           = alu_add;
        ctrl.mem_byte_enable = 2'b11;

        case (opcode)
            op_add: begin
                ctrl.aluop        = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = 2'b10;    // second operand is sext of ir 4:0
                end
            end
            op_and: begin
                ctrl.aluop        = alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                if (imm_enable) begin
                    ctrl.alumux_sel = 2'b10;
                end
            end
            op_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_shf: begin
                ctrl.alumux_sel = 2'b11;        // shift amount from ir 3:0
                if (!d_enable) begin
                    ctrl.aluop = alu_sll;
                end else if (!imm_enable) begin
                    ctrl.aluop = alu_srl;       // logical right shift fills with zero
                end else begin
                    ctrl.aluop = alu_sra;       // arithmetic right shift keeps the sign
                end
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_ldr: begin
                ctrl.aluop          = alu_add;
                ctrl.alumux_sel     = 2'b01;    // base plus offset6 forms the address
                ctrl.load_mar       = 1'b1;
                ctrl.mdrmux_sel     = 1'b1;
                ctrl.load_mdr       = 1'b1;
                ctrl.mem_read       = 1'b1;
                ctrl.regfilemux_sel = 2'b01;    // write back the loaded word
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end
            op_ldb: begin
                ctrl.aluop                 = alu_add;
                ctrl.alumux_sel            = 2'b01;
                ctrl.offset6mux_sel        = 1'b1;  // byte offset is not shifted
                ctrl.load_mar              = 1'b1;
                ctrl.mdrmux_sel            = 1'b1;
                ctrl.load_mdr              = 1'b1;
                ctrl.mem_read              = 1'b1;
                ctrl.regfilemux_sel        = 2'b01;
                ctrl.regfile_filter_enable = 1'b1;
                ctrl.load_regfile          = 1'b1;
                ctrl.load_cc               = 1'b1;
            end
            op_ldi: begin
                ctrl.indirect_enable = 1'b1;    // the first read returns the real address
                ctrl.aluop           = alu_add;
                ctrl.alumux_sel      = 2'b01;
                ctrl.load_mar        = 1'b1;
                ctrl.mdrmux_sel      = 1'b1;
                ctrl.load_mdr        = 1'b1;
                ctrl.mem_read        = 1'b1;
                ctrl.regfilemux_sel  = 2'b01;
                ctrl.load_regfile    = 1'b1;
                ctrl.load_cc         = 1'b1;
            end
            op_str: begin
                ctrl.aluop        = alu_add;
                ctrl.alumux_sel   = 2'b01;
                ctrl.load_mar     = 1'b1;
                ctrl.storemux_sel = 1'b1;       // source register sits in ir 11:9
                ctrl.load_mdr     = 1'b1;
                ctrl.mem_write    = 1'b1;
            end
            op_stb: begin
                ctrl.aluop             = alu_add;
                ctrl.alumux_sel        = 2'b01;
                ctrl.offset6mux_sel    = 1'b1;
                ctrl.load_mar          = 1'b1;
                ctrl.storemux_sel      = 1'b1;
                ctrl.stb_filter_enable = 1'b1;
                ctrl.load_mdr          = 1'b1;
                ctrl.mem_byte_enable   = stb_high_enable ? 2'b10 : 2'b01;
                ctrl.mem_write         = 1'b1;
            end
            op_sti: begin
                ctrl.indirect_enable = 1'b1;
                ctrl.aluop           = alu_add;
                ctrl.alumux_sel      = 2'b01;
                ctrl.load_mar        = 1'b1;
                ctrl.mdrmux_sel      = 1'b1;
                ctrl.load_mdr        = 1'b1;
                ctrl.storemux_sel    = 1'b1;
            end
            op_br: begin
                if (!is_nop) begin
                    ctrl.brmux_sel = 1'b1;      // branch target is pc plus offset9
                    ctrl.load_pc   = 1'b1;
                end
            end
            op_jmp: begin
                ctrl.pcmux_sel = 2'b10;         // jump target comes from the base register
                ctrl.load_pc   = 1'b1;
            end
            op_jsr: begin
                ctrl.destmux_sel    = 1'b1;     // link address goes to R7
                ctrl.regfilemux_sel = 2'b11;
                ctrl.load_regfile   = 1'b1;
                if (jsr_enable) begin
                    ctrl.offsetaddermux_sel = 1'b1;
                    ctrl.pcmux_sel          = 2'b01;
                end else begin
                    ctrl.pcmux_sel = 2'b10;     // JSRR takes the base register
                end
                ctrl.load_pc = 1'b1;
            end
            op_lea: begin
                ctrl.regfilemux_sel = 2'b10;
                ctrl.load_regfile   = 1'b1;
            end
            op_trap: begin
                ctrl.destmux_sel    = 1'b1;
                ctrl.regfilemux_sel = 2'b11;
                ctrl.load_regfile   = 1'b1;
                ctrl.marmux_sel     = 2'b11;    // vector table entry at trapvect8 times two
                ctrl.load_mar       = 1'b1;
                ctrl.mdrmux_sel     = 1'b1;
                ctrl.load_mdr       = 1'b1;
                ctrl.mem_read       = 1'b1;
                ctrl.pcmux_sel      = 2'b11;
                ctrl.load_pc        = 1'b1;
            end
            default: begin
                ctrl = '0;                      // RTI and anything else decode to nothing
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== design/decode_lane.sv ====
`default_nettype none

module decode_lane import lc3b_types::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  decode_in_t  push_data,
    input  logic        pop,
    output logic        valid,
    output decode_out_t result
);

    decode_in_t            entry [LANE_DEPTH];  // payload storage
    logic [LANE_PTR_W-1:0] wr_ptr;
    logic [LANE_PTR_W-1:0] rd_ptr;
    logic [LANE_CNT_W-1:0] count;
    decode_in_t            head;
    lc3b_control_word      ctrl;

    // ------------------------------
    // lane buffer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + LANE_CNT_W'(push) - LANE_CNT_W'(pop);
        end
    end

    assign valid = (count != '0);
    assign head  = entry[rd_ptr];

    // ------------------------------
    // decode of the head entry
    // ------------------------------
    control_rom u_rom (
        .opcode          (lc3b_opcode'(head.ir[15:12])),
        .imm_enable      (head.ir[5]),
        .jsr_enable      (head.ir[11]),
        .d_enable        (head.ir[4]),
        .stb_high_enable (head.addr_lsb),
        .is_nop          (head.ir[11:9] == 3'b000),    // BR with no condition bits set
        .ctrl            (ctrl)
    );

    always_comb begin
        result.pc   = head.pc;
        result.ir   = head.ir;
        result.ctrl = ctrl;
        result.dest = ctrl.destmux_sel ? 3'd7 : head.ir[11:9];
        result.sr1  = head.ir[8:6];
        result.sr2  = ctrl.storemux_sel ? head.ir[11:9] : head.ir[2:0];
    end

    // the dispatcher credit count must keep the lane from overflowing
    assert property (@(posedge clk) disable iff (rst)
        !(push && count == LANE_CNT_W'(LANE_DEPTH)));

    assert property (@(posedge clk) disable iff (rst) pop |-> valid);

endmodule : decode_lane

`default_nettype wire

// ==== design/decode_dispatch.sv ====
`default_nettype none

module decode_dispatch import lc3b_types::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  decode_in_t           in_data,
    output logic                 in_credit,
    output logic [NUM_LANES-1:0] lane_push,
    output decode_in_t           lane_data,
    input  logic [NUM_LANES-1:0] lane_credit
);

    decode_in_t            in_buf [IN_DEPTH];
    logic [IN_PTR_W-1:0]   wr_ptr;
    logic [IN_PTR_W-1:0]   rd_ptr;
    logic [IN_CNT_W-1:0]   in_count;
    logic [LANE_IDX_W-1:0] rr_ptr;              // lane that receives the next entry
    logic [LANE_CNT_W-1:0] lane_cnt [NUM_LANES];
    logic                  send;

    // strict round-robin so the pointer waits on a lane without credit
    assign send      = (in_count != '0) && (lane_cnt[rr_ptr] != '0);
    assign in_credit = send;                    // slot freed at this edge
    assign lane_data = in_buf[rd_ptr];

    always_comb begin
        lane_push         = '0;
        lane_push[rr_ptr] = send;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            in_buf[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            in_count <= '0;
            rr_ptr   <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
                rr_ptr <= rr_ptr + 1'b1;
            end
            in_count <= in_count + IN_CNT_W'(in_valid) - IN_CNT_W'(send);
        end
    end

    // ------------------------------
    // per-lane credit counters
    // ------------------------------
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_credit
        always_ff @(posedge clk) begin
            if (rst) begin
                lane_cnt[g] <= LANE_CNT_W'(LANE_DEPTH);
            end else begin
                lane_cnt[g] <= lane_cnt[g] + LANE_CNT_W'(lane_credit[g])
                               - LANE_CNT_W'(lane_push[g]);
            end
        end

        assert property (@(posedge clk) disable iff (rst) lane_cnt[g] <= LANE_DEPTH);
    end

    // the upstream sender must honour its credits
    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> in_count != IN_CNT_W'(IN_DEPTH));

endmodule : decode_dispatch

`default_nettype wire

// ==== design/decode_collect.sv ====
`default_nettype none

module decode_collect import lc3b_types::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LANES-1:0] lane_valid,
    input  decode_out_t          lane_out [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_pop,
    output logic [NUM_LANES-1:0] lane_credit,
    output logic                 out_valid,
    output decode_out_t          out_data,
    input  logic                 out_credit
);

    logic [LANE_IDX_W-1:0] rr_ptr;              // follows the dispatcher pointer
    logic [OUT_CNT_W-1:0]  credit;
    logic                  take;

    // ------------------------------
    // in-order drain
    // ------------------------------
    assign take = lane_valid[rr_ptr] && (credit != '0);    // holds with no credit left

    always_comb begin
        lane_pop         = '0;
        lane_pop[rr_ptr] = take;
    end

    assign lane_credit = lane_pop;              // each pop frees one lane slot

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
            credit <= OUT_CNT_W'(OUT_CREDITS);
        end else begin
            if (take) begin
                rr_ptr <= rr_ptr + 1'b1;
            end
            credit <= credit + OUT_CNT_W'(out_credit) - OUT_CNT_W'(take);
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= lane_out[rr_ptr];
        end
    end

    // a consumer returning more credits than it was given would break this
    assert property (@(posedge clk) disable iff (rst) credit <= OUT_CREDITS);

endmodule : decode_collect

`default_nettype wire

// ==== design/decode_unit.sv ====
`default_nettype none

module decode_unit import lc3b_types::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  decode_in_t  in_data,
    output logic        in_credit,
    output logic        out_valid,
    output decode_out_t out_data,
    input  logic        out_credit
);

    logic [NUM_LANES-1:0] lane_push;
    decode_in_t           lane_data;            // shared by all lanes
    logic [NUM_LANES-1:0] lane_credit;
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_pop;
    decode_out_t          lane_out [NUM_LANES];

    decode_dispatch u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_credit   (in_credit),
        .lane_push   (lane_push),
        .lane_data   (lane_data),
        .lane_credit (lane_credit)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        decode_lane u_lane (
            .clk       (clk),
            .rst       (rst),
            .push      (lane_push[i]),
            .push_data (lane_data),
            .pop       (lane_pop[i]),
            .valid     (lane_valid[i]),
            .result    (lane_out[i])
        );
    end

    decode_collect u_collect (
        .clk         (clk),
        .rst         (rst),
        .lane_valid  (lane_valid),
        .lane_out    (lane_out),
        .lane_pop    (lane_pop),
        .lane_credit (lane_credit),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_credit  (out_credit)
    );

endmodule : decode_unit

`default_nettype wire

// ==== tb/decode_expect.svh ====
`ifndef DECODE_EXPECT_SVH
`define DECODE_EXPECT_SVH

function automatic lc3b_opcode op_of(input logic [15:0] ir);
    return lc3b_opcode'(ir[15:12]);
endfunction

// the ALU ops and the three loads write a register and set the condition codes
function automatic logic writes_reg_and_cc(input logic [15:0] ir);
    case (op_of(ir))
        op_add, op_and, op_not, op_shf, op_ldr, op_ldb, op_ldi: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic reads_memory(input logic [15:0] ir);
    case (op_of(ir))
        op_ldr, op_ldb, op_ldi, op_trap: return 1'b1;  // trap reads its vector
        default: return 1'b0;
    endcase
endfunction

function automatic logic writes_memory(input logic [15:0] ir);
    return (op_of(ir) == op_str) || (op_of(ir) == op_stb);
endfunction

function automatic logic [1:0] stb_byte_lanes(input logic addr_lsb);
    return addr_lsb ? 2'b10 : 2'b01;                    // odd address hits the high byte
endfunction

// ir 5 is the arithmetic bit and ir 4 the direction bit
function automatic alu_ops shift_aluop(input logic [15:0] ir);
    if (!ir[4]) begin
        return alu_sll;
    end
    return ir[5] ? alu_sra : alu_srl;
endfunction

function automatic logic branch_loads_pc(input logic [15:0] ir);
    return ir[11:9] != 3'b000;                          // no nzp bits means a nop
endfunction

function automatic logic links_r7(input logic [15:0] ir);
    return (op_of(ir) == op_jsr) || (op_of(ir) == op_trap);
endfunction

`endif

// ==== tb/tb_decode_unit.sv ====
`default_nettype none

module tb_decode_unit import lc3b_types::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR  = 600;
    localparam int MAX_CYCLES = 4000;           // roughly three times a normal run
    localparam int HOLD_AT    = 300;            // sent count that opens the stall phase
    localparam int HOLD_LEN   = 50;

    logic        clk;
    logic        rst;
    logic        in_valid;
    decode_in_t  in_data;
    logic        in_credit;
    logic        out_valid;
    decode_out_t out_data;
    logic        out_credit;

    decode_in_t  sent_q [$];                    // scoreboard in program order
    decode_in_t  head;
    logic        head_ok;
    int          in_credits;
    int          in_outstanding;
    int          in_sent;
    int          out_seen;
    int          out_returned;
    int          owed;                          // packets taken but not yet credited back
    int          hold_left;
    logic        hold_done;
    int          cycle;
    logic [15:0] next_pc;

    `include "decode_expect.svh"

    decode_unit u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        abort_run($sformatf("Mismatch at %0t ns: %s expected %0h actual %0h",
                            $time, name, expected, actual));
    endtask

    function automatic decode_in_t random_instr(input logic [15:0] pc);
        decode_in_t d;
        d.pc       = pc;
        d.ir       = 16'($urandom);             // opcode and operands together
        d.addr_lsb = 1'($urandom);
        return d;
    endfunction

    // ------------------------------
    // one clock of stimulus
    // ------------------------------
    task automatic step_cycle();
        decode_in_t item;
        @(posedge clk);
        in_outstanding += int'(in_valid) - int'(in_credit);   // values seen at this edge
        if (in_credit) begin
            in_credits++;
        end
        if (out_credit) begin
            out_returned++;
        end
        if (out_valid) begin
            void'(sent_q.pop_front());
            out_seen++;
            owed++;
        end
        if (in_sent < NUM_INSTR && in_credits > 0 && $urandom_range(3) != 0) begin
            item = random_instr(next_pc);
            in_valid <= 1'b1;
            in_data  <= item;
            sent_q.push_back(item);
            next_pc += 16'd2;
            in_sent++;
            in_credits--;
        end else begin
            in_valid <= 1'b0;
        end
        if (!hold_done && in_sent >= HOLD_AT) begin
            hold_left = HOLD_LEN;               // downstream stops returning credits
            hold_done = 1'b1;
        end
        if (hold_left > 0) begin
            hold_left--;
            out_credit <= 1'b0;
        end else if (owed > 0 && $urandom_range(1) == 1) begin
            out_credit <= 1'b1;
            owed--;
        end else begin
            out_credit <= 1'b0;
        end
        head_ok = (sent_q.size() != 0);
        if (head_ok) begin
            head = sent_q[0];
        end
    endtask

    initial begin
        void'($urandom(32'hbe3f_a4dc));
        clk            = 1'b0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_data        = '0;
        out_credit     = 1'b0;
        head           = '0;
        head_ok        = 1'b0;
        in_credits     = IN_DEPTH;
        in_outstanding = 0;
        in_sent        = 0;
        out_seen       = 0;
        out_returned   = 0;
        owed           = 0;
        hold_left      = 0;
        hold_done      = 1'b0;
        cycle          = 0;
        next_pc        = 16'h3000;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (out_seen < NUM_INSTR) begin
            step_cycle();
        end
        repeat (20) step_cycle();               // quiet tail catches any extra packet
        if (in_credits == IN_DEPTH && sent_q.size() == 0 && out_seen == NUM_INSTR) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("run ended with %0d input credits back and %0d packets missing",
                                in_credits, sent_q.size()));
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d packets out",
                                cycle, out_seen, NUM_INSTR));
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_no_extra: assert property (@(posedge clk) disable iff (rst) out_valid |-> head_ok)
        else abort_run("a packet came out with no instruction left to match it");
    a_pc: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_data.pc == head.pc)
        else report_mismatch("out_data.pc", $sampled(head.pc), $sampled(out_data.pc));
    a_ir: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_data.ir == head.ir)
        else report_mismatch("out_data.ir", $sampled(head.ir), $sampled(out_data.ir));
    a_regfile: assert property (@(posedge clk) disable iff (rst)
        out_valid && writes_reg_and_cc(head.ir) |-> out_data.ctrl.load_regfile)
        else report_mismatch("out_data.ctrl.load_regfile", 1,
                             $sampled(out_data.ctrl.load_regfile));
    a_cc: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_data.ctrl.load_cc == writes_reg_and_cc(head.ir))
        else report_mismatch("out_data.ctrl.load_cc", writes_reg_and_cc($sampled(head.ir)),
                             $sampled(out_data.ctrl.load_cc));
    a_mem_read: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_data.ctrl.mem_read == reads_memory(head.ir))
        else report_mismatch("out_data.ctrl.mem_read", reads_memory($sampled(head.ir)),
                             $sampled(out_data.ctrl.mem_read));
    a_mem_write: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_data.ctrl.mem_write == writes_memory(head.ir))
        else report_mismatch("out_data.ctrl.mem_write", writes_memory($sampled(head.ir)),
                             $sampled(out_data.ctrl.mem_write));
    a_stb_bytes: assert property (@(posedge clk) disable iff (rst)
        out_valid && op_of(head.ir) == op_stb
        |-> out_data.ctrl.mem_byte_enable == stb_byte_lanes(head.addr_lsb))
        else report_mismatch("out_data.ctrl.mem_byte_enable",
                             stb_byte_lanes($sampled(head.addr_lsb)),
                             $sampled(out_data.ctrl.mem_byte_enable));
    a_shift: assert property (@(posedge clk) disable iff (rst)
        out_valid && op_of(head.ir) == op_shf |-> out_data.ctrl.aluop == shift_aluop(head.ir))
        else report_mismatch("out_data.ctrl.aluop", shift_aluop($sampled(head.ir)),
                             $sampled(out_data.ctrl.aluop));
    a_rti: assert property (@(posedge clk) disable iff (rst)
        out_valid && op_of(head.ir) == op_rti |-> out_data.ctrl == '0)
        else report_mismatch("out_data.ctrl", 0, $sampled(out_data.ctrl));
    a_link: assert property (@(posedge clk) disable iff (rst)
        out_valid && links_r7(head.ir) |-> out_data.dest == 3'd7)
        else report_mismatch("out_data.dest", 7, $sampled(out_data.dest));
    a_sr1: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_data.sr1 == head.ir[8:6])
        else report_mismatch("out_data.sr1", $sampled(head.ir[8:6]), $sampled(out_data.sr1));
    a_store_src: assert property (@(posedge clk) disable iff (rst)
        out_valid && writes_memory(head.ir) |-> out_data.sr2 == head.ir[11:9])
        else report_mismatch("out_data.sr2", $sampled(head.ir[11:9]), $sampled(out_data.sr2));
    a_branch: assert property (@(posedge clk) disable iff (rst)
        out_valid && op_of(head.ir) == op_br |-> out_data.ctrl.load_pc == branch_loads_pc(head.ir))
        else report_mismatch("out_data.ctrl.load_pc", branch_loads_pc($sampled(head.ir)),
                             $sampled(out_data.ctrl.load_pc));
    a_out_credit: assert property (@(posedge clk) disable iff (rst)
        out_seen <= OUT_CREDITS + out_returned)
        else abort_run("more packets came out than downstream credits allow");
    a_in_return: assert property (@(posedge clk) disable iff (rst) in_credit |-> in_outstanding > 0)
        else abort_run("an input credit came back with no instruction outstanding");

endmodule : tb_decode_unit

`default_nettype wire

// ==== vlog.f ====
+incdir+tb
design/lc3b_types.sv
design/control_rom.sv
design/decode_lane.sv
design/decode_dispatch.sv
design/decode_collect.sv
design/decode_unit.sv
tb/tb_decode_unit.sv

// ==== Bender.yml ====
package:
  name: lc3b_decode_unit

sources:
  - design/lc3b_types.sv
  - design/control_rom.sv
  - design/decode_lane.sv
  - design/decode_dispatch.sv
  - design/decode_collect.sv
  - design/decode_unit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_decode_unit.sv
